//--- hw/mem_pkg.sv
// sizes are fixed by the 64-bit tagged memory bus and a memory tag of zero always means no transaction
`default_nettype none

package mem_pkg;

	////////////////////////////////////////////////////////////
	// bus and cache geometry
	////////////////////////////////////////////////////////////

	// byte address
	localparam int addr_width = 32;
	// one memory word is one cache block
	localparam int block_width = 64;
	// memory transaction tag, zero is reserved
	localparam int tag_width = 4;

	// 32 direct-mapped lines
	localparam int index_bits = 5;
	localparam int num_lines = 1 << index_bits;
	// byte offset inside a block
	localparam int offset_bits = 3;
	localparam int line_tag_bits = addr_width - index_bits - offset_bits;

	// bus controller client slots, data side wins arbitration
	localparam int num_clients = 2;
	localparam logic client_data = 1'b0;
	localparam logic client_fetch = 1'b1;

	////////////////////////////////////////////////////////////
	// memory command encoding
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		bus_none = 2'h0,
		bus_load = 2'h1,
		bus_store = 2'h2
	} bus_command_e;

	////////////////////////////////////////////////////////////
	// client requests and replies
	////////////////////////////////////////////////////////////

	// instruction fetch, whole block comes back
	typedef struct packed {
		logic [addr_width-1:0] addr;
	} fetch_req_t;

	// uncached doubleword access
	typedef struct packed {
		logic store;
		logic [addr_width-1:0] addr;
		logic [block_width-1:0] data;
	} data_req_t;

	// load data, or zero for a finished store
	typedef struct packed {
		logic [block_width-1:0] data;
	} mem_reply_t;

	// what a client hands to the bus controller
	typedef struct packed {
		bus_command_e command;
		logic [addr_width-1:0] addr;
		logic [block_width-1:0] data;
	} bus_req_t;

endpackage

`default_nettype wire

//--- hw/icache.sv
// direct-mapped and read-only so stores to cached blocks are not seen, one fetch in flight at a time
`timescale 1ns/1ps
`default_nettype none

module icache (
	input wire logic clock,
	input wire logic reset,

	// fetch port
	input wire logic fetch_valid,
	input wire mem_pkg::fetch_req_t fetch_req,
	output logic fetch_ready,
	output logic fetch_reply_valid,
	output mem_pkg::mem_reply_t fetch_reply,

	// miss link to the bus controller
	output logic miss_valid,
	output mem_pkg::bus_req_t miss_req,
	input wire logic miss_ready,
	input wire logic fill_valid,
	input wire mem_pkg::mem_reply_t fill_data
);

	import mem_pkg::*;

	typedef enum logic [1:0] {
		state_idle,
		state_lookup,
		state_miss_request,
		state_wait_fill
	} icache_state_e;

	icache_state_e state;
	icache_state_e state_next;

	// line storage
	logic [num_lines-1:0] line_valid;
	logic [line_tag_bits-1:0] line_tag [num_lines];
	logic [block_width-1:0] line_data [num_lines];

	// address of the fetch being served
	logic [index_bits-1:0] req_index;
	logic [line_tag_bits-1:0] req_tag;

	logic fetch_accept;
	logic hit;
	logic fill_write;

	////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////

	assign fetch_ready = (state == state_idle);
	assign fetch_accept = fetch_valid && fetch_ready;

	// array read uses the registered index, so a hit answers one cycle after accept
	assign hit = line_valid[req_index] && (line_tag[req_index] == req_tag);

	// fill lands in the line in the same cycle it is returned to fetch
	assign fill_write = (state == state_wait_fill) && fill_valid;

	// block load, offset bits cleared
	assign miss_req.command = bus_load;
	assign miss_req.addr = {req_tag, req_index, {offset_bits{1'b0}}};
	assign miss_req.data = '0;

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		fetch_reply_valid = 1'b0;
		fetch_reply.data = line_data[req_index];
		miss_valid = 1'b0;
		case (state)
			state_idle: begin
				if (fetch_valid) begin
					state_next = state_lookup;
				end
			end
			state_lookup: begin
				// hit answers straight from the array
				if (hit) begin
					fetch_reply_valid = 1'b1;
					state_next = state_idle;
				end else begin
					state_next = state_miss_request;
				end
			end
			state_miss_request: begin
				// held until the controller takes it
				miss_valid = 1'b1;
				if (miss_ready) begin
					state_next = state_wait_fill;
				end
			end
			state_wait_fill: begin
				// pass the fill through to fetch
				if (fill_valid) begin
					fetch_reply_valid = 1'b1;
					fetch_reply.data = fill_data.data;
					state_next = state_idle;
				end
			end
			default: begin
				state_next = state_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_idle;
			line_valid <= '0;
		end else begin
			state <= state_next;
			if (fill_write) begin
				line_valid[req_index] <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		// split address on accept, byte offset dropped
		if (fetch_accept) begin
			req_index <= fetch_req.addr[offset_bits +: index_bits];
			req_tag <= fetch_req.addr[addr_width-1 -: line_tag_bits];
		end
		if (fill_write) begin
			line_tag[req_index] <= req_tag;
			line_data[req_index] <= fill_data.data;
		end
	end

endmodule

`default_nettype wire

//--- hw/bus_controller.sv
// one request per client at a time and data always wins the bus, memory tags must be unique while outstanding
`timescale 1ns/1ps
`default_nettype none

module bus_controller (
	input wire logic clock,
	input wire logic reset,

	// icache miss link
	input wire logic miss_valid,
	input wire mem_pkg::bus_req_t miss_req,
	output logic miss_ready,
	output logic fill_valid,
	output mem_pkg::mem_reply_t fill_data,

	// uncached data port
	input wire logic data_valid,
	input wire mem_pkg::data_req_t data_req,
	output logic data_ready,
	output logic data_reply_valid,
	output mem_pkg::mem_reply_t data_reply,

	// tagged memory bus
	output mem_pkg::bus_command_e mem_command,
	output logic [mem_pkg::addr_width-1:0] mem_addr,
	output logic [mem_pkg::block_width-1:0] mem_wdata,
	input wire logic [mem_pkg::tag_width-1:0] mem_response,
	input wire logic [mem_pkg::block_width-1:0] mem_rdata,
	input wire logic [mem_pkg::tag_width-1:0] mem_rtag
);

	import mem_pkg::*;

	// idle takes a request, issue waits for the bus, wait waits for the tag, done replies
	typedef enum logic [1:0] {
		slot_idle,
		slot_issue,
		slot_wait,
		slot_done
	} slot_state_e;

	// per client slot, index by client_data or client_fetch
	slot_state_e state [num_clients];
	bus_req_t slot_req [num_clients];
	logic [tag_width-1:0] slot_tag [num_clients];
	logic [block_width-1:0] slot_data [num_clients];

	// client side requests in a common shape
	logic in_valid [num_clients];
	bus_req_t in_req [num_clients];

	logic grant_valid;
	logic grant_client;
	logic accepted;
	logic [num_clients-1:0] issue_done;
	logic [num_clients-1:0] reply_hit;

	always_comb begin
		in_valid[client_data] = data_valid;
		in_req[client_data].command = data_req.store ? bus_store : bus_load;
		in_req[client_data].addr = data_req.addr;
		in_req[client_data].data = data_req.data;
		in_valid[client_fetch] = miss_valid;
		in_req[client_fetch] = miss_req;
	end

	////////////////////////////////////////////////////////////
	// arbitration
	////////////////////////////////////////////////////////////

	// data first, miss only when data has nothing to send
	always_comb begin
		grant_valid = 1'b1;
		grant_client = client_data;
		if (state[client_data] == slot_issue) begin
			grant_client = client_data;
		end else if (state[client_fetch] == slot_issue) begin
			grant_client = client_fetch;
		end else begin
			grant_valid = 1'b0;
		end
	end

	// a refused command stays on the bus next cycle
	assign mem_command = grant_valid ? slot_req[grant_client].command : bus_none;
	assign mem_addr = slot_req[grant_client].addr;
	assign mem_wdata = slot_req[grant_client].data;
	assign accepted = grant_valid && (mem_response != '0);

	always_comb begin
		for (int i = 0; i < num_clients; i++) begin
			issue_done[i] = accepted && (grant_client == 1'(i));
			// tag zero never matches
			reply_hit[i] = (state[i] == slot_wait) && (mem_rtag != '0)
				&& (mem_rtag == slot_tag[i]);
		end
	end

	////////////////////////////////////////////////////////////
	// slot state
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_clients; i++) begin
				state[i] <= slot_idle;
			end
		end else begin
			for (int i = 0; i < num_clients; i++) begin
				case (state[i])
					slot_idle: begin
						if (in_valid[i]) begin
							state[i] <= slot_issue;
						end
					end
					slot_issue: begin
						// store is complete once memory takes it
						if (issue_done[i]) begin
							state[i] <= (slot_req[i].command == bus_store) ? slot_done : slot_wait;
						end
					end
					slot_wait: begin
						if (reply_hit[i]) begin
							state[i] <= slot_done;
						end
					end
					default: begin
						state[i] <= slot_idle;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < num_clients; i++) begin
			if ((state[i] == slot_idle) && in_valid[i]) begin
				slot_req[i] <= in_req[i];
			end
			// keep the response tag, zero block stands for a store reply
			if (issue_done[i]) begin
				slot_tag[i] <= mem_response;
				slot_data[i] <= '0;
			end
			if (reply_hit[i]) begin
				slot_data[i] <= mem_rdata;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// client outputs
	////////////////////////////////////////////////////////////

	// ready only in idle, so it stays low through the reply cycle
	assign data_ready = (state[client_data] == slot_idle);
	assign miss_ready = (state[client_fetch] == slot_idle);

	assign data_reply_valid = (state[client_data] == slot_done);
	assign data_reply.data = slot_data[client_data];
	assign fill_valid = (state[client_fetch] == slot_done);
	assign fill_data.data = slot_data[client_fetch];

endmodule

`default_nettype wire

//--- hw/mem_subsystem.sv
// fetch and data ports each hold one request at a time and share a single tagged memory bus
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
	input wire logic clock,
	input wire logic reset,

	// instruction fetch
	input wire logic fetch_valid,
	input wire mem_pkg::fetch_req_t fetch_req,
	output logic fetch_ready,
	output logic fetch_reply_valid,
	output mem_pkg::mem_reply_t fetch_reply,

	// uncached data
	input wire logic data_valid,
	input wire mem_pkg::data_req_t data_req,
	output logic data_ready,
	output logic data_reply_valid,
	output mem_pkg::mem_reply_t data_reply,

	// memory bus
	output mem_pkg::bus_command_e mem_command,
	output logic [mem_pkg::addr_width-1:0] mem_addr,
	output logic [mem_pkg::block_width-1:0] mem_wdata,
	input wire logic [mem_pkg::tag_width-1:0] mem_response,
	input wire logic [mem_pkg::block_width-1:0] mem_rdata,
	input wire logic [mem_pkg::tag_width-1:0] mem_rtag
);

	import mem_pkg::*;

	// icache to controller
	logic miss_valid;
	bus_req_t miss_req;
	logic miss_ready;
	logic fill_valid;
	mem_reply_t fill_data;

	////////////////////////////////////////////////////////////
	// instruction cache
	////////////////////////////////////////////////////////////

	icache icache_0 (
		.clock(clock),
		.reset(reset),
		.fetch_valid(fetch_valid),
		.fetch_req(fetch_req),
		.fetch_ready(fetch_ready),
		.fetch_reply_valid(fetch_reply_valid),
		.fetch_reply(fetch_reply),
		.miss_valid(miss_valid),
		.miss_req(miss_req),
		.miss_ready(miss_ready),
		.fill_valid(fill_valid),
		.fill_data(fill_data)
	);

	////////////////////////////////////////////////////////////
	// bus controller, data port goes straight in
	////////////////////////////////////////////////////////////

	bus_controller bus_controller_0 (
		.clock(clock),
		.reset(reset),
		.miss_valid(miss_valid),
		.miss_req(miss_req),
		.miss_ready(miss_ready),
		.fill_valid(fill_valid),
		.fill_data(fill_data),
		.data_valid(data_valid),
		.data_req(data_req),
		.data_ready(data_ready),
		.data_reply_valid(data_reply_valid),
		.data_reply(data_reply),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_response(mem_response),
		.mem_rdata(mem_rdata),
		.mem_rtag(mem_rtag)
	);

endmodule

`default_nettype wire

//--- tests/tb_checker.sv
// keeps its own memory and cache copy, assumes a fetch and a store never touch one block at once
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input wire logic clock,
	input wire logic reset,
	input wire logic fetch_valid,
	input wire mem_pkg::fetch_req_t fetch_req,
	input wire logic fetch_ready,
	input wire logic fetch_reply_valid,
	input wire mem_pkg::mem_reply_t fetch_reply,
	input wire logic [mem_pkg::block_width-1:0] fetch_expect,
	input wire logic data_valid,
	input wire mem_pkg::data_req_t data_req,
	input wire logic data_ready,
	input wire logic data_reply_valid,
	input wire mem_pkg::mem_reply_t data_reply,
	input wire logic [mem_pkg::block_width-1:0] data_expect,
	input wire mem_pkg::bus_command_e mem_command,
	input wire logic [mem_pkg::addr_width-1:0] mem_addr,
	input wire logic [mem_pkg::block_width-1:0] mem_wdata,
	input wire logic [mem_pkg::tag_width-1:0] mem_response,
	output int error_count
);

	import mem_pkg::*;

	// memory after accepted stores
	logic [block_width-1:0] mem_copy [logic [addr_width-offset_bits-1:0]];
	// what the cache should hold
	logic line_valid [num_lines];
	logic [line_tag_bits-1:0] line_tag [num_lines];
	logic [block_width-1:0] line_data [num_lines];

	logic seen_request;
	logic fetch_busy;
	logic fetch_hit;
	logic fetch_unsent;
	int fetch_age;
	logic [addr_width-1:0] fetch_addr;
	logic [addr_width-1:0] fetch_base;
	logic [block_width-1:0] fetch_exp;
	logic data_busy;
	logic data_unsent;
	logic data_store;
	logic [addr_width-1:0] data_addr;
	logic [block_width-1:0] data_wdata;
	logic [block_width-1:0] data_exp;

	initial error_count = 0;

	function automatic logic [block_width-1:0] block_of(input logic [addr_width-1:0] addr);
		logic [addr_width-1:0] base;
		base = {addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
		if (mem_copy.exists(addr[addr_width-1:offset_bits])) begin
			return mem_copy[addr[addr_width-1:offset_bits]];
		end
		return {base, ~base};
	endfunction

	task automatic compare_value(input string name, input logic [block_width-1:0] expected,
		input logic [block_width-1:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h got %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("%0t ns: %s", $time, what);
		error_count++;
	endtask

	////////////////////////////////////////////////////////////
	// per cycle checks
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		logic [block_width-1:0] model;
		int idx;
		if (reset) begin
			seen_request = 1'b0;
			fetch_busy = 1'b0;
			fetch_unsent = 1'b0;
			data_busy = 1'b0;
			data_unsent = 1'b0;
			foreach (line_valid[i]) begin
				line_valid[i] = 1'b0;
			end
		end else begin
			if (!seen_request && mem_command != bus_none) begin
				report_problem("bus command issued before any request");
			end else if (data_unsent && mem_command != bus_none) begin
				// a data command not yet taken owns the bus
				compare_value("mem_addr", data_addr, mem_addr);
				compare_value("mem_command", data_store ? bus_store : bus_load, mem_command);
				if (data_store) begin
					compare_value("mem_wdata", data_wdata, mem_wdata);
				end
				if (mem_response != '0) begin
					// memory copy follows the store that was asked for
					if (data_store) begin
						mem_copy[data_addr[addr_width-1:offset_bits]] = data_wdata;
					end
					data_unsent = 1'b0;
				end
			end else if (mem_command != bus_none) begin
				// anything else must be the block load of a fetch miss
				if (!fetch_unsent) begin
					report_problem("bus command with no request waiting for the bus");
				end else begin
					compare_value("mem_addr", fetch_base, mem_addr);
					compare_value("mem_command", bus_load, mem_command);
					if (mem_response != '0) begin
						fetch_unsent = 1'b0;
					end
				end
			end
			if (fetch_busy) begin
				fetch_age++;
			end
			if (fetch_busy && fetch_ready) begin
				report_problem("fetch_ready rose before the reply");
			end
			if (data_busy && data_ready) begin
				report_problem("data_ready rose before the reply");
			end
			// fetch reply, hit from the cache copy, miss from memory
			idx = fetch_addr[offset_bits +: index_bits];
			if (fetch_reply_valid && !fetch_busy) begin
				report_problem("fetch reply without a request");
			end else if (fetch_reply_valid) begin
				model = fetch_hit ? line_data[idx] : block_of(fetch_addr);
				if (fetch_hit && fetch_age != 1) begin
					report_problem($sformatf("fetch hit replied after %0d cycles", fetch_age));
				end
				if (fetch_unsent) begin
					report_problem("fetch replied before memory took its block load");
				end
				compare_value("fetch_reply", fetch_exp, fetch_reply.data);
				if (model !== fetch_exp) begin
					report_problem("stimulus table and memory copy disagree on a fetch");
				end
				line_valid[idx] = 1'b1;
				line_tag[idx] = fetch_addr[addr_width-1 -: line_tag_bits];
				line_data[idx] = model;
				fetch_busy = 1'b0;
			end
			// data reply, zero block for a store
			if (data_reply_valid && !data_busy) begin
				report_problem("data reply without a request");
			end else if (data_reply_valid) begin
				model = data_store ? '0 : block_of(data_addr);
				compare_value("data_reply", data_exp, data_reply.data);
				if (model !== data_exp) begin
					report_problem("stimulus table and memory copy disagree on a data reply");
				end
				data_busy = 1'b0;
			end
			// new requests
			if (fetch_valid && fetch_ready) begin
				seen_request = 1'b1;
				fetch_busy = 1'b1;
				fetch_age = 0;
				fetch_addr = fetch_req.addr;
				fetch_base = {fetch_req.addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
				fetch_exp = fetch_expect;
				idx = fetch_req.addr[offset_bits +: index_bits];
				fetch_hit = line_valid[idx]
					&& (line_tag[idx] == fetch_req.addr[addr_width-1 -: line_tag_bits]);
				// only a miss goes out on the bus
				fetch_unsent = !fetch_hit;
			end
			if (data_valid && data_ready) begin
				seen_request = 1'b1;
				data_busy = 1'b1;
				data_unsent = 1'b1;
				data_store = data_req.store;
				data_addr = data_req.addr;
				data_wdata = data_req.data;
				data_exp = data_expect;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_mem_subsystem.sv
// memory model refuses one command in four, answers loads 1 to 6 cycles later and out of order
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

	import mem_pkg::*;

	localparam int timeout_cycles = 200;
	localparam int num_rows = 18;
	localparam logic port_fetch = 1'b0;
	localparam logic port_data = 1'b1;

	// one stimulus row with the reply it must produce
	typedef struct packed {
		// falling edges to wait before the row is sent
		logic [1:0] gap;
		logic port;
		logic store;
		logic [addr_width-1:0] addr;
		logic [block_width-1:0] wdata;
		logic [block_width-1:0] reply;
	} row_t;

	logic clock;
	logic reset;
	logic fetch_valid;
	fetch_req_t fetch_req;
	logic fetch_ready;
	logic fetch_reply_valid;
	mem_reply_t fetch_reply;
	logic data_valid;
	data_req_t data_req;
	logic data_ready;
	logic data_reply_valid;
	mem_reply_t data_reply;
	bus_command_e mem_command;
	logic [addr_width-1:0] mem_addr;
	logic [block_width-1:0] mem_wdata;
	logic [tag_width-1:0] mem_response;
	logic [block_width-1:0] mem_rdata;
	logic [tag_width-1:0] mem_rtag;
	logic [block_width-1:0] fetch_expect;
	logic [block_width-1:0] data_expect;
	int scoreboard_errors;
	int timeouts;
	int waited;
	row_t rows [num_rows];

	// memory contents written by stores, keyed by block address
	logic [block_width-1:0] memory [logic [addr_width-offset_bits-1:0]];
	// load replies still to be sent
	logic [tag_width-1:0] pend_tag [$];
	logic [block_width-1:0] pend_data [$];
	int pend_delay [$];

	mem_subsystem dut (.*);

	tb_checker scoreboard (
		.clock(clock), .reset(reset),
		.fetch_valid(fetch_valid), .fetch_req(fetch_req), .fetch_ready(fetch_ready),
		.fetch_reply_valid(fetch_reply_valid), .fetch_reply(fetch_reply),
		.fetch_expect(fetch_expect),
		.data_valid(data_valid), .data_req(data_req), .data_ready(data_ready),
		.data_reply_valid(data_reply_valid), .data_reply(data_reply),
		.data_expect(data_expect),
		.mem_command(mem_command), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_response(mem_response), .error_count(scoreboard_errors)
	);

	always #20 clock = ~clock;

	// untouched block holds its address on top and the complement below
	function automatic logic [block_width-1:0] read_block(input logic [addr_width-1:0] addr);
		logic [addr_width-1:0] base;
		base = {addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
		if (memory.exists(addr[addr_width-1:offset_bits])) begin
			return memory[addr[addr_width-1:offset_bits]];
		end
		return {base, ~base};
	endfunction

	////////////////////////////////////////////////////////////
	// tagged memory model
	////////////////////////////////////////////////////////////

	task automatic serve_memory();
		logic [tag_width-1:0] next_tag;
		int pick;
		next_tag = 4'd1;
		forever begin
			@(negedge clock);
			pick = -1;
			// count down, at most one reply per cycle
			foreach (pend_delay[i]) begin
				if (pend_delay[i] > 0) begin
					pend_delay[i]--;
				end
				if (pend_delay[i] == 0 && pick < 0) begin
					pick = i;
				end
			end
			mem_rtag <= '0;
			if (pick >= 0) begin
				mem_rtag <= pend_tag[pick];
				mem_rdata <= pend_data[pick];
				pend_tag.delete(pick);
				pend_data.delete(pick);
				pend_delay.delete(pick);
			end
			// accept in the same cycle, or refuse and see it again next cycle
			mem_response <= '0;
			if (!reset && (mem_command == bus_load || mem_command == bus_store)
				&& $urandom_range(3) != 0) begin
				mem_response <= next_tag;
				if (mem_command == bus_store) begin
					memory[mem_addr[addr_width-1:offset_bits]] = mem_wdata;
				end else begin
					pend_tag.push_back(next_tag);
					pend_data.push_back(read_block(mem_addr));
					pend_delay.push_back($urandom_range(6, 1));
				end
				next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	// called at a falling edge, ready there holds until the next rising edge
	task automatic send_row(input row_t r);
		int count;
		count = 0;
		repeat (r.gap) @(negedge clock);
		while (!(r.port == port_data ? data_ready : fetch_ready) && count < timeout_cycles) begin
			@(negedge clock);
			count++;
		end
		if (count >= timeout_cycles) begin
			$display("port never became ready for address %h", r.addr);
			timeouts++;
		end else begin
			if (r.port == port_data) begin
				data_valid = 1'b1;
				data_req = '{store: r.store, addr: r.addr, data: r.wdata};
				data_expect = r.reply;
			end else begin
				fetch_valid = 1'b1;
				fetch_req.addr = r.addr;
				fetch_expect = r.reply;
			end
			@(negedge clock);
			data_valid = 1'b0;
			fetch_valid = 1'b0;
		end
	endtask

	initial begin
		void'($urandom(32'h7705_80e3));
		clock = 1'b0;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_req = '0;
		data_valid = 1'b0;
		data_req = '0;
		fetch_expect = '0;
		data_expect = '0;
		mem_response = '0;
		mem_rdata = '0;
		mem_rtag = '0;
		timeouts = 0;
		// gap, port, store, address, store data, reply
		rows[0] = {2'd0, port_fetch, 1'b0, 32'h0000_1000, 64'h0, 64'h0000_1000_ffff_efff};
		// data request reaches the controller with the miss, data goes first
		rows[1] = {2'd1, port_data, 1'b0, 32'h0000_2008, 64'h0, 64'h0000_2008_ffff_dff7};
		rows[2] = {2'd0, port_fetch, 1'b0, 32'h0000_1004, 64'h0, 64'h0000_1000_ffff_efff};
		rows[3] = {2'd0, port_data, 1'b1, 32'h0000_1000, 64'hcafe_f00d_1234_5678, 64'h0};
		rows[4] = {2'd0, port_data, 1'b0, 32'h0000_1000, 64'h0, 64'hcafe_f00d_1234_5678};
		// cache is not snooped, still the old block
		rows[5] = {2'd0, port_fetch, 1'b0, 32'h0000_1000, 64'h0, 64'h0000_1000_ffff_efff};
		rows[6] = {2'd0, port_fetch, 1'b0, 32'h0000_3010, 64'h0, 64'h0000_3010_ffff_cfef};
		rows[7] = {2'd0, port_data, 1'b1, 32'h0000_4018, 64'h0123_4567_89ab_cdef, 64'h0};
		rows[8] = {2'd0, port_data, 1'b0, 32'h0000_4018, 64'h0, 64'h0123_4567_89ab_cdef};
		rows[9] = {2'd0, port_fetch, 1'b0, 32'h0000_5020, 64'h0, 64'h0000_5020_ffff_afdf};
		rows[10] = {2'd0, port_data, 1'b0, 32'h0000_6028, 64'h0, 64'h0000_6028_ffff_9fd7};
		// same index as 0x1000, evicts it
		rows[11] = {2'd0, port_fetch, 1'b0, 32'h0000_1400, 64'h0, 64'h0000_1400_ffff_ebff};
		rows[12] = {2'd0, port_fetch, 1'b0, 32'h0000_1000, 64'h0, 64'hcafe_f00d_1234_5678};
		rows[13] = {2'd0, port_data, 1'b0, 32'h0000_5020, 64'h0, 64'h0000_5020_ffff_afdf};
		rows[14] = {2'd0, port_fetch, 1'b0, 32'h0000_5020, 64'h0, 64'h0000_5020_ffff_afdf};
		rows[15] = {2'd0, port_data, 1'b1, 32'h0000_1000, 64'hdead_beef_0000_0001, 64'h0};
		rows[16] = {2'd0, port_fetch, 1'b0, 32'h0000_1000, 64'h0, 64'hcafe_f00d_1234_5678};
		rows[17] = {2'd0, port_data, 1'b0, 32'h0000_1000, 64'h0, 64'hdead_beef_0000_0001};
		fork
			serve_memory();
		join_none
		repeat (8) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < num_rows; i++) begin
			send_row(rows[i]);
		end
		// both ports back to ready means every reply came
		waited = 0;
		while (!(fetch_ready && data_ready) && waited < timeout_cycles) begin
			@(negedge clock);
			waited++;
		end
		if (waited >= timeout_cycles) begin
			$display("ports still busy at the end of the run, a reply is missing");
			timeouts++;
		end
		@(negedge clock);
		$display("checker errors %0d, timeouts %0d", scoreboard_errors, timeouts);
		if (scoreboard_errors == 0 && timeouts == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
hw/mem_pkg.sv
hw/icache.sv
hw/bus_controller.sv
hw/mem_subsystem.sv
tests/tb_checker.sv
tests/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - hw/mem_pkg.sv
  - hw/icache.sv
  - hw/bus_controller.sv
  - hw/mem_subsystem.sv
  - target: test
    files:
      - tests/tb_checker.sv
      - tests/tb_mem_subsystem.sv
